// File: pio_rrsp_pkg.sv
package pio_rrsp_pkg;

    // ********************
    // bus and field widths
    // ********************
    localparam int pio_data_w      = 64;   // data bus width
    localparam int cc_byte_cnt_lsb = 16;   // byte count inside cc_head
    localparam int cc_byte_cnt_msb = 28;
    localparam int cc_dw_cnt_lsb   = 32;   // dw count field, 11 bits
    localparam int cc_low_addr_w   = 7;    // lower address field

    typedef logic [pio_data_w-1:0] pio_data_t;

    // payload size code, 0 is 128B and each step doubles up to 4096B
    typedef logic [2:0] max_pyld_t;

    // ********************
    // header formats
    // ********************
    typedef struct packed {
        logic        is_wr;
        logic [2:0]  bar_id;
        logic [31:0] addr;      // byte address of first byte
        logic [95:0] cc_head;   // completion header
    } pio_head_t;

    typedef struct packed {
        pio_head_t   pio_head;
        logic [3:0]  first_be;
        logic [3:0]  last_be;
        logic [10:0] dw_cnt;
        logic [31:0] aligned_addr;   // addr with [1:0] cleared
    } align_head_t;

    typedef struct packed {
        logic [3:0]  first_be;
        logic [3:0]  last_be;
        logic [31:0] addr;      // aligned address of the chunk
        logic [95:0] cc_head;   // rewritten header
    } cpl_head_t;

endpackage

// File: pio_stream_if.sv
interface pio_stream_if #(
    parameter type head_t = logic
) ();
    import pio_rrsp_pkg::*;

    pio_data_t data;
    head_t     head;    // valid on first beat of a packet
    logic      last;
    logic      valid;
    logic      ready;

    modport src (
        output data,
        output head,
        output last,
        output valid,
        input  ready
    );

    modport snk (
        input  data,
        input  head,
        input  last,
        input  valid,
        output ready
    );

endinterface

// File: pio_rrsp_ctrl.sv
module pio_rrsp_ctrl #(
    parameter int CHANNEL_NUM = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [CHANNEL_NUM-1:0]         chnl_valid,   // per channel request
    input  logic [CHANNEL_NUM-1:0]         chnl_last,
    input  logic                           beat_acc,     // beat taken by the mux
    output logic                           grant_vld,
    output logic [$clog2(CHANNEL_NUM)-1:0] grant_idx     // doubles as rr pointer
);
    localparam int idx_w = $clog2(CHANNEL_NUM);

    logic             nxt_found;
    logic [idx_w-1:0] nxt_idx;
    logic [idx_w-1:0] cand;

    // search starts one past the last granted channel
    always_comb begin
        nxt_found = 1'b0;
        nxt_idx   = grant_idx;   // no request keeps the pointer
        cand      = grant_idx;
        for (int i = 1; i <= CHANNEL_NUM; i++) begin
            cand = idx_w'((int'(grant_idx) + i) % CHANNEL_NUM);
            if (!nxt_found && chnl_valid[cand]) begin
                nxt_found = 1'b1;   // first hit wins
                nxt_idx   = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_vld <= 1'b0;
            grant_idx <= idx_w'(CHANNEL_NUM - 1);   // ch 0 first after reset
        end else if (!grant_vld) begin
            grant_vld <= nxt_found;                // lock for a whole packet
            grant_idx <= nxt_idx;
        end else if (beat_acc && chnl_last[grant_idx]) begin
            grant_vld <= 1'b0;                     // last beat gone, unlock
        end
    end

endmodule

// File: pio_mux.sv
module pio_mux #(
    parameter int CHANNEL_NUM = 4
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  pio_rrsp_pkg::pio_data_t [CHANNEL_NUM-1:0] chnl_data,
    input  pio_rrsp_pkg::pio_head_t [CHANNEL_NUM-1:0] chnl_head,
    input  logic [CHANNEL_NUM-1:0]                    chnl_last,
    input  logic [CHANNEL_NUM-1:0]                    chnl_valid,
    output logic [CHANNEL_NUM-1:0]                    chnl_ready,
    input  logic                                      grant_vld,
    input  logic [$clog2(CHANNEL_NUM)-1:0]            grant_idx,
    output logic                                      beat_acc,   // one pulse per beat
    pio_stream_if.src                                 mux_s
);
    logic sel_valid;
    logic stage_rdy;

    assign sel_valid = grant_vld & chnl_valid[grant_idx];
    assign stage_rdy = !mux_s.valid || mux_s.ready;   // empty or draining
    assign beat_acc  = sel_valid & stage_rdy;

    // only the granted channel sees ready
    always_comb begin
        chnl_ready            = '0;
        chnl_ready[grant_idx] = grant_vld & stage_rdy;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mux_s.valid <= 1'b0;
        end else if (stage_rdy) begin
            mux_s.valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_acc) begin
            mux_s.data <= chnl_data[grant_idx];
            mux_s.head <= chnl_head[grant_idx];
            mux_s.last <= chnl_last[grant_idx];
        end
    end

endmodule

// File: pio_dw_align.sv
module pio_dw_align (
    input  logic      clk,
    input  logic      arst_n,
    pio_stream_if.snk mux_s,
    pio_stream_if.src align_s
);
    import pio_rrsp_pkg::*;

    localparam int bc_w = cc_byte_cnt_msb - cc_byte_cnt_lsb + 1;

    // ********************
    // first beat math
    // ********************
    logic [1:0]              in_off;      // lane of the first byte
    logic [bc_w-1:0]         byte_cnt;
    logic [bc_w-1:0]         bc_m1;
    logic [bc_w-1:0]         end_byte;    // last byte offset from aligned addr
    logic [3:0]              end_be;      // lanes up to the last byte
    logic [3:0]              start_be;
    logic [3:0]              tail_sum;
    logic                    tail_need;   // shifted bytes spill past last beat
    logic [10:0]             dw_cnt;

    logic                    first_q;     // next input beat opens a packet
    logic [1:0]              off_q;
    logic                    need_q;
    logic                    tail_q;      // overflow beat pending
    pio_data_t               carry_q;     // bytes pushed out of the last beat
    logic [1:0]              cur_off;
    logic                    cur_need;
    logic [2*pio_data_w-1:0] wide;
    logic                    stage_rdy;
    logic                    in_acc;

    assign in_off    = mux_s.head.addr[1:0];
    assign byte_cnt  = mux_s.head.cc_head[cc_byte_cnt_msb:cc_byte_cnt_lsb];
    assign bc_m1     = byte_cnt - 1'b1;
    assign end_byte  = bc_m1 + bc_w'(in_off);
    assign dw_cnt    = 11'(end_byte[bc_w-1:2]) + 11'd1;
    assign end_be    = 4'hf >> (2'd3 - end_byte[1:0]);
    assign start_be  = 4'hf << in_off;
    assign tail_sum  = {1'b0, bc_m1[2:0]} + {2'b00, in_off};
    assign tail_need = tail_sum[3];   // carry out of the 8 lanes

    assign cur_off   = first_q ? in_off : off_q;
    assign cur_need  = first_q ? tail_need : need_q;
    assign wide      = {{pio_data_w{1'b0}}, mux_s.data} << {cur_off, 3'b000};
    assign stage_rdy = !align_s.valid || align_s.ready;

    assign mux_s.ready = stage_rdy && !tail_q;   // input held off on tail beat
    assign in_acc      = mux_s.valid && mux_s.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            align_s.valid <= 1'b0;
            first_q       <= 1'b1;
            tail_q        <= 1'b0;
        end else if (stage_rdy) begin
            align_s.valid <= tail_q || in_acc;
            if (tail_q) begin
                tail_q <= 1'b0;
            end else if (in_acc) begin
                first_q <= mux_s.last;
                tail_q  <= mux_s.last && cur_need;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_rdy && tail_q) begin
            align_s.data <= carry_q;   // leftover bytes only
            align_s.last <= 1'b1;
        end else if (in_acc) begin
            align_s.data <= wide[pio_data_w-1:0] | (first_q ? '0 : carry_q);
            align_s.last <= mux_s.last && !cur_need;
            carry_q      <= wide[2*pio_data_w-1:pio_data_w];
            if (first_q) begin
                off_q                     <= in_off;
                need_q                    <= tail_need;
                align_s.head.pio_head     <= mux_s.head;
                align_s.head.first_be     <= (dw_cnt == 11'd1) ? (start_be & end_be) : start_be;
                align_s.head.last_be      <= (dw_cnt == 11'd1) ? 4'h0 : end_be;
                align_s.head.dw_cnt       <= dw_cnt;
                align_s.head.aligned_addr <= {mux_s.head.addr[31:2], 2'b00};
            end
        end
    end

endmodule

// File: pio_rsp_split.sv
module pio_rsp_split (
    input  logic                    clk,
    input  logic                    arst_n,
    input  pio_rrsp_pkg::max_pyld_t max_pyld_sz,   // static while a packet flows
    pio_stream_if.snk               align_s,
    pio_stream_if.src               split_s
);
    import pio_rrsp_pkg::*;

    logic [9:0]  chunk_beats;   // payload bytes / 8
    logic [10:0] chunk_dws;
    logic [8:0]  beat_q;        // beat index inside the chunk
    logic [10:0] dw_sent_q;     // dws in chunks already closed
    align_head_t head_q;        // packet header kept from beat 0
    align_head_t pkt_head;
    align_head_t chunk_head;
    logic [10:0] dw_left;
    logic        more;          // another chunk follows this one
    logic        pkt_first;
    logic        chunk_end;
    logic        stage_rdy;
    logic        in_acc;

    assign chunk_beats = 10'd16 << max_pyld_sz;
    assign chunk_dws   = {chunk_beats, 1'b0};
    assign pkt_first   = (dw_sent_q == '0) && (beat_q == '0);
    assign pkt_head    = pkt_first ? align_s.head : head_q;
    assign dw_left     = pkt_head.dw_cnt - dw_sent_q;
    assign more        = dw_left > chunk_dws;
    assign chunk_end   = (beat_q == 9'(chunk_beats - 1'b1)) || align_s.last;
    assign stage_rdy   = !split_s.valid || split_s.ready;

    assign align_s.ready = stage_rdy;
    assign in_acc        = align_s.valid && stage_rdy;

    // ********************
    // per chunk header
    // ********************
    always_comb begin
        chunk_head              = pkt_head;
        chunk_head.dw_cnt       = more ? chunk_dws : dw_left;
        chunk_head.aligned_addr = pkt_head.aligned_addr + 32'({dw_sent_q, 2'b00});
        chunk_head.first_be     = pkt_first ? pkt_head.first_be : 4'hf;
        chunk_head.last_be      = more ? 4'hf : pkt_head.last_be;   // final chunk keeps it
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            split_s.valid <= 1'b0;
            beat_q        <= '0;
            dw_sent_q     <= '0;
        end else if (stage_rdy) begin
            split_s.valid <= align_s.valid;
            if (in_acc) begin
                if (align_s.last) begin
                    beat_q    <= '0;
                    dw_sent_q <= '0;                      // ready for next packet
                end else if (chunk_end) begin
                    beat_q    <= '0;
                    dw_sent_q <= dw_sent_q + chunk_dws;   // full chunk gone
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_acc) begin
            split_s.data <= align_s.data;
            split_s.last <= chunk_end;   // forced at the size boundary
            if (pkt_first) begin
                head_q <= align_s.head;
            end
            if (beat_q == '0) begin
                split_s.head <= chunk_head;
            end
        end
    end

endmodule

// File: pio_cpl_head.sv
module pio_cpl_head (
    input  logic                    clk,
    input  logic                    arst_n,
    pio_stream_if.snk               split_s,
    output pio_rrsp_pkg::pio_data_t cpl_data,
    output logic [3:0]              cpl_first_be,
    output logic [3:0]              cpl_last_be,
    output logic [31:0]             cpl_addr,
    output logic [95:0]             cpl_cc_head,
    output logic                    cpl_last,
    output logic                    cpl_valid,
    input  logic                    cpl_ready
);
    import pio_rrsp_pkg::*;

    cpl_head_t  nxt_head;
    cpl_head_t  head_q;
    pio_data_t  data_q;
    logic [1:0] first_empty;   // dead bytes ahead of the first valid one
    logic       stage_rdy;

    assign stage_rdy     = !cpl_valid || cpl_ready;
    assign split_s.ready = stage_rdy;

    // lowest set bit of first_be
    always_comb begin
        first_empty = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (split_s.head.first_be[i]) begin
                first_empty = 2'(i);
            end
        end
    end

    always_comb begin
        nxt_head          = '0;
        nxt_head.first_be = split_s.head.first_be;
        nxt_head.last_be  = split_s.head.last_be;
        nxt_head.addr     = split_s.head.aligned_addr;
        nxt_head.cc_head  = split_s.head.pio_head.cc_head;   // byte count left as is
        nxt_head.cc_head[cc_dw_cnt_lsb +: 11] = split_s.head.dw_cnt;
        nxt_head.cc_head[cc_low_addr_w-1:0] =
            {split_s.head.aligned_addr[cc_low_addr_w-1:2], first_empty};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cpl_valid <= 1'b0;
        end else if (stage_rdy) begin
            cpl_valid <= split_s.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (split_s.valid && stage_rdy) begin
            data_q   <= split_s.data;
            head_q   <= nxt_head;
            cpl_last <= split_s.last;   // end of completion
        end
    end

    assign cpl_data     = data_q;
    assign cpl_first_be = head_q.first_be;
    assign cpl_last_be  = head_q.last_be;
    assign cpl_addr     = head_q.addr;
    assign cpl_cc_head  = head_q.cc_head;

endmodule

// File: pio_rrsp.sv
module pio_rrsp #(
    parameter int CHANNEL_NUM = 4
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  pio_rrsp_pkg::pio_data_t [CHANNEL_NUM-1:0] chnl_data,
    input  pio_rrsp_pkg::pio_head_t [CHANNEL_NUM-1:0] chnl_head,
    input  logic [CHANNEL_NUM-1:0]                    chnl_last,
    input  logic [CHANNEL_NUM-1:0]                    chnl_valid,
    output logic [CHANNEL_NUM-1:0]                    chnl_ready,
    input  pio_rrsp_pkg::max_pyld_t                   max_pyld_sz,
    output pio_rrsp_pkg::pio_data_t                   cpl_data,
    output logic [3:0]                                cpl_first_be,
    output logic [3:0]                                cpl_last_be,
    output logic [31:0]                               cpl_addr,
    output logic [95:0]                               cpl_cc_head,
    output logic                                      cpl_last,
    output logic                                      cpl_valid,
    input  logic                                      cpl_ready
);
    import pio_rrsp_pkg::*;

    logic                           grant_vld;
    logic [$clog2(CHANNEL_NUM)-1:0] grant_idx;
    logic                           beat_acc;

    pio_stream_if #(.head_t(pio_head_t))   mux_s ();     // mux -> align
    pio_stream_if #(.head_t(align_head_t)) align_s ();   // align -> split
    pio_stream_if #(.head_t(align_head_t)) split_s ();   // split -> header rewrite

    pio_rrsp_ctrl #(.CHANNEL_NUM(CHANNEL_NUM)) pio_rrsp_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .chnl_valid (chnl_valid),
        .chnl_last  (chnl_last),
        .beat_acc   (beat_acc),
        .grant_vld  (grant_vld),
        .grant_idx  (grant_idx)
    );

    pio_mux #(.CHANNEL_NUM(CHANNEL_NUM)) pio_mux_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .chnl_data  (chnl_data),
        .chnl_head  (chnl_head),
        .chnl_last  (chnl_last),
        .chnl_valid (chnl_valid),
        .chnl_ready (chnl_ready),
        .grant_vld  (grant_vld),
        .grant_idx  (grant_idx),
        .beat_acc   (beat_acc),
        .mux_s      (mux_s.src)
    );

    pio_dw_align pio_dw_align_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .mux_s   (mux_s.snk),
        .align_s (align_s.src)
    );

    pio_rsp_split pio_rsp_split_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .max_pyld_sz (max_pyld_sz),
        .align_s     (align_s.snk),
        .split_s     (split_s.src)
    );

    pio_cpl_head pio_cpl_head_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .split_s      (split_s.snk),
        .cpl_data     (cpl_data),
        .cpl_first_be (cpl_first_be),
        .cpl_last_be  (cpl_last_be),
        .cpl_addr     (cpl_addr),
        .cpl_cc_head  (cpl_cc_head),
        .cpl_last     (cpl_last),
        .cpl_valid    (cpl_valid),
        .cpl_ready    (cpl_ready)
    );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);          // release away from the active edge
        arst_n = 1'b1;
    end

endmodule

// File: pio_rrsp_props.sv
module pio_rrsp_props (
    input logic                    clk,
    input logic                    arst_n,
    input pio_rrsp_pkg::pio_data_t cpl_data,
    input logic [3:0]              cpl_first_be,
    input logic [3:0]              cpl_last_be,
    input logic [95:0]             cpl_cc_head,
    input logic [31:0]             cpl_addr,
    input logic                    cpl_last,
    input logic                    cpl_valid,
    input logic                    cpl_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_fails = 0;   // read by the testbench top at the end

    // a stalled beat is not withdrawn
    valid_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        cpl_valid && !cpl_ready |=> cpl_valid)
        else begin
            assert_fails++;
            $error("cpl_valid dropped while stalled");
        end

    // a stalled beat stays put
    hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        cpl_valid && !cpl_ready |=> $stable(cpl_data) && $stable(cpl_last)
            && $stable(cpl_first_be) && $stable(cpl_last_be)
            && $stable(cpl_cc_head) && $stable(cpl_addr))
        else begin
            assert_fails++;
            $error("cpl beat changed while stalled");
        end

    no_valid_in_reset: assert property (@(posedge clk) !arst_n |-> !cpl_valid)
        else begin
            assert_fails++;
            $error("cpl_valid high during reset");
        end

endmodule

bind pio_rrsp pio_rrsp_props pio_rrsp_props_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cpl_data     (cpl_data),
    .cpl_first_be (cpl_first_be),
    .cpl_last_be  (cpl_last_be),
    .cpl_cc_head  (cpl_cc_head),
    .cpl_addr     (cpl_addr),
    .cpl_last     (cpl_last),
    .cpl_valid    (cpl_valid),
    .cpl_ready    (cpl_ready)
);

// File: tb_pio_rrsp.sv
module tb_pio_rrsp;
    timeunit 1ns;
    timeprecision 100ps;
    import pio_rrsp_pkg::*;

    localparam int chan_num = 4;
    localparam int max_pkt  = 16;
    localparam int max_chk  = 64;
    localparam int timeout  = 5000;   // cycles per wait
    localparam int tag_lsb  = 8;      // tag sits in cc_head[15:8]

    logic                           clk;
    logic                           arst_n;
    pio_data_t [chan_num-1:0]       chnl_data;
    pio_head_t [chan_num-1:0]       chnl_head;
    logic [chan_num-1:0]            chnl_last;
    logic [chan_num-1:0]            chnl_valid;
    logic [chan_num-1:0]            chnl_ready;
    max_pyld_t                      max_pyld_sz;
    pio_data_t                      cpl_data;
    logic [3:0]                     cpl_first_be;
    logic [3:0]                     cpl_last_be;
    logic [31:0]                    cpl_addr;
    logic [95:0]                    cpl_cc_head;
    logic                           cpl_last;
    logic                           cpl_valid;
    logic                           cpl_ready;

    // ********************
    // stimulus tables
    // ********************
    logic [31:0] stim [0:511];
    logic [31:0] p_chan [0:max_pkt-1];
    logic [31:0] p_addr [0:max_pkt-1];
    logic [31:0] p_bc [0:max_pkt-1];
    logic [31:0] p_tag [0:max_pkt-1];
    logic [31:0] p_mps [0:max_pkt-1];
    int          p_nchk [0:max_pkt-1];
    int          p_chk0 [0:max_pkt-1];   // first chunk row of the packet
    logic [31:0] c_row [0:max_chk-1][0:4];
    logic [7:0]  pkt_bytes [0:max_pkt-1][0:4095];
    int          npkt = 0;
    integer      seed = 32'h4b0e;

    // scoreboard state
    int pkt_chunk [0:max_pkt-1];
    int pkt_beat [0:max_pkt-1];
    int last_done [0:chan_num-1];
    int cur_pkt = -1;   // packet whose chunks are leaving
    bit in_cpl = 1'b0;
    int done_cnt = 0;

    tb_clk_gen tb_clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    pio_rrsp #(.CHANNEL_NUM(chan_num)) pio_rrsp_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .chnl_data    (chnl_data),
        .chnl_head    (chnl_head),
        .chnl_last    (chnl_last),
        .chnl_valid   (chnl_valid),
        .chnl_ready   (chnl_ready),
        .max_pyld_sz  (max_pyld_sz),
        .cpl_data     (cpl_data),
        .cpl_first_be (cpl_first_be),
        .cpl_last_be  (cpl_last_be),
        .cpl_addr     (cpl_addr),
        .cpl_cc_head  (cpl_cc_head),
        .cpl_last     (cpl_last),
        .cpl_valid    (cpl_valid),
        .cpl_ready    (cpl_ready)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_head(input cpl_head_t got, input cpl_head_t exp);
        if (got.first_be !== exp.first_be)
            report_failure($sformatf("mismatch cpl_first_be got %h exp %h",
                                     got.first_be, exp.first_be));
        if (got.last_be !== exp.last_be)
            report_failure($sformatf("mismatch cpl_last_be got %h exp %h",
                                     got.last_be, exp.last_be));
        if (got.addr !== exp.addr)
            report_failure($sformatf("mismatch cpl_addr got %h exp %h",
                                     got.addr, exp.addr));
        if (got.cc_head !== exp.cc_head)
            report_failure($sformatf("mismatch cpl_cc_head got %h exp %h",
                                     got.cc_head, exp.cc_head));
    endtask

    task automatic compare_data(input pio_data_t got, input pio_data_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch cpl_data got %h exp %h", got, exp));
    endtask

    task automatic compare_last(input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("mismatch cpl_last got %h exp %h", got, exp));
    endtask

    task automatic load_stimulus();
        int idx;
        int n_rows;
        idx    = 0;
        n_rows = 0;
        $readmemh("pio_rrsp_stimulus.txt", stim);
        while (stim[idx] !== 32'hff && npkt < max_pkt) begin
            p_chan[npkt] = stim[idx];
            p_addr[npkt] = stim[idx+1];
            p_bc[npkt]   = stim[idx+2];
            p_tag[npkt]  = stim[idx+3];
            p_mps[npkt]  = stim[idx+4];
            p_nchk[npkt] = int'(stim[idx+5]);
            p_chk0[npkt] = n_rows;
            idx += 6;
            for (int j = 0; j < p_nchk[npkt]; j++) begin
                for (int f = 0; f < 5; f++) begin
                    c_row[n_rows][f] = stim[idx+f];
                end
                idx += 5;
                n_rows++;
            end
            pkt_chunk[npkt] = 0;
            pkt_beat[npkt]  = 0;
            npkt++;
        end
        if (npkt == 0)
            report_failure("stimulus file holds no packets");
    endtask

    // completion header as sent with packet p
    function automatic logic [95:0] build_cc_head(input int p);
        logic [95:0] h;
        h = {3{p_addr[p] ^ {4{p_tag[p][7:0]}}}};   // filler the DUT must pass through
        h[cc_byte_cnt_msb:cc_byte_cnt_lsb] = p_bc[p][12:0];
        h[tag_lsb +: 8] = p_tag[p][7:0];
        return h;
    endfunction

    // input beat k of packet p with zeros past the byte count
    function automatic pio_data_t in_beat(input int p, input int k);
        pio_data_t d;
        int        s;
        d = '0;
        for (int l = 0; l < 8; l++) begin
            s = k * 8 + l;
            if (s < int'(p_bc[p])) d[l*8 +: 8] = pkt_bytes[p][s];
        end
        return d;
    endfunction

    // output beat k with the first byte moved up to lane addr[1:0]
    function automatic pio_data_t exp_beat(input int p, input int k);
        pio_data_t d;
        int        s;
        d = '0;
        for (int l = 0; l < 8; l++) begin
            s = k * 8 + l - int'(p_addr[p][1:0]);
            if (s >= 0 && s < int'(p_bc[p])) d[l*8 +: 8] = pkt_bytes[p][s];
        end
        return d;
    endfunction

    function automatic int next_of_chan(input int c);
        for (int p = last_done[c] + 1; p < npkt; p++) begin
            if (int'(p_chan[p]) == c) return p;
        end
        return -1;
    endfunction

    function automatic int find_pkt(input logic [7:0] tag);
        for (int p = 0; p < npkt; p++) begin
            if (p_tag[p][7:0] == tag) return p;
        end
        return -1;
    endfunction

    task automatic drive_channel(input int c, input int gs, input int ge);
        pio_head_t h;
        int        nbeats;
        int        wait_cnt;
        for (int p = gs; p < ge; p++) begin
            if (int'(p_chan[p]) == c) begin
                h = '0;
                h.addr = p_addr[p];
                h.cc_head = build_cc_head(p);
                nbeats = (int'(p_bc[p]) + 7) / 8;
                for (int k = 0; k < nbeats; k++) begin
                    @(posedge clk);   // previous beat went on this edge
                    chnl_valid[c] <= 1'b1;
                    chnl_data[c]  <= in_beat(p, k);
                    chnl_head[c]  <= h;
                    chnl_last[c]  <= (k == nbeats - 1);
                    wait_cnt = 0;
                    do begin
                        @(negedge clk);
                        wait_cnt++;
                        if (wait_cnt > timeout)
                            report_failure($sformatf("channel %0d never got ready", c));
                    end while (!chnl_ready[c]);
                end
            end
        end
        @(posedge clk);
        chnl_valid[c] <= 1'b0;
    endtask

    task automatic check_beat();
        cpl_head_t exp_h;
        cpl_head_t got_h;
        int        p;
        int        row;
        int        total;
        int        cbeats;
        logic      exp_l;
        p = find_pkt(cpl_cc_head[tag_lsb +: 8]);
        if (!in_cpl) begin   // first beat of a completion
            if (p < 0)
                report_failure("completion carries an unknown tag");
            if (cur_pkt >= 0 && p != cur_pkt)
                report_failure("completions of two packets interleaved");
            if (cur_pkt < 0 && p != next_of_chan(int'(p_chan[p])))
                report_failure($sformatf("packet %0d left out of channel order", p));
            if (pkt_chunk[p] >= p_nchk[p])
                report_failure($sformatf("packet %0d has too many completions", p));
            cur_pkt = p;
            row = p_chk0[p] + pkt_chunk[p];
            exp_h = '0;
            exp_h.first_be = c_row[row][0][3:0];
            exp_h.last_be  = c_row[row][1][3:0];
            exp_h.addr     = c_row[row][2];
            exp_h.cc_head  = build_cc_head(p);
            exp_h.cc_head[cc_dw_cnt_lsb +: 11] = c_row[row][3][10:0];
            exp_h.cc_head[cc_low_addr_w-1:0] = c_row[row][4][cc_low_addr_w-1:0];
            got_h = {cpl_first_be, cpl_last_be, cpl_addr, cpl_cc_head};
            compare_head(got_h, exp_h);
            in_cpl = 1'b1;
        end else if (p != cur_pkt) begin
            report_failure("tag changed inside a completion");
        end
        compare_data(cpl_data, exp_beat(p, pkt_beat[p]));
        total  = (int'(p_addr[p][1:0]) + int'(p_bc[p]) + 7) / 8;
        cbeats = 16 << p_mps[p];   // beats per max payload
        exp_l  = (pkt_beat[p] == total - 1) || ((pkt_beat[p] + 1) % cbeats == 0);
        compare_last(cpl_last, exp_l);
        pkt_beat[p]++;
        if (cpl_last) begin
            in_cpl = 1'b0;
            pkt_chunk[p]++;
            if (pkt_beat[p] == total) begin
                if (pkt_chunk[p] != p_nchk[p])
                    report_failure($sformatf("packet %0d split into wrong chunk count", p));
                last_done[p_chan[p]] = p;
                cur_pkt = -1;
                done_cnt++;
            end
        end
    endtask

    // ********************
    // output side
    // ********************
    initial begin
        cpl_ready = 1'b0;
        forever begin
            @(posedge clk);
            cpl_ready <= ($random(seed) & 3) != 0;   // about one stall in four
        end
    end

    initial begin
        forever begin
            @(negedge clk);   // outputs settled here
            if (arst_n && cpl_valid && cpl_ready) check_beat();
        end
    end

    initial begin : main
        int gs;
        int ge;
        int wait_cnt;
        chnl_valid  = '0;
        chnl_data   = '0;
        chnl_head   = '0;
        chnl_last   = '0;
        max_pyld_sz = '0;
        for (int c = 0; c < chan_num; c++) last_done[c] = -1;
        load_stimulus();
        for (int p = 0; p < npkt; p++) begin
            for (int b = 0; b < int'(p_bc[p]); b++) pkt_bytes[p][b] = 8'($random(seed));
        end
        wait_cnt = 0;
        while (!arst_n) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > timeout) report_failure("reset never released");
        end
        gs = 0;
        while (gs < npkt) begin   // one group per payload size
            ge = gs;
            while (ge < npkt && p_mps[ge] == p_mps[gs]) ge++;
            @(posedge clk);
            max_pyld_sz <= max_pyld_t'(p_mps[gs]);
            fork
                drive_channel(0, gs, ge);
                drive_channel(1, gs, ge);
                drive_channel(2, gs, ge);
                drive_channel(3, gs, ge);
            join
            wait_cnt = 0;
            while (done_cnt < ge) begin
                @(negedge clk);
                wait_cnt++;
                if (wait_cnt > timeout) report_failure("completions stopped arriving");
            end
            gs = ge;
        end
        repeat (4) @(negedge clk);
        if (done_cnt == npkt && !in_cpl && pio_rrsp_i.pio_rrsp_props_i.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("run ended with packets or assertions outstanding");
        end
    end

endmodule

// File: pio_rrsp.f
pio_rrsp_pkg.sv
pio_stream_if.sv
pio_rrsp_ctrl.sv
pio_mux.sv
pio_dw_align.sv
pio_rsp_split.sv
pio_cpl_head.sv
pio_rrsp.sv
tb_clk_gen.sv
pio_rrsp_props.sv
tb_pio_rrsp.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_pio_rrsp -f pio_rrsp.f
status=0
out=$(./obj_dir/Vtb_pio_rrsp) || status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    exit 1
fi
printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"

// File: pio_rrsp_stimulus.txt
// chan addr bytes tag mps chunks, then per chunk: first_be last_be addr dw_cnt low_addr
// ff ends the list
0 00001000 0008 00 0 1 f f 00001000 002 00
1 00002001 0003 01 0 1 e 0 00002000 001 01
2 00003022 000d 02 0 1 c 7 00003020 004 22
3 00004043 0001 03 0 1 8 0 00004040 001 43
0 00001100 012c 04 0 3 f f 00001100 020 00 f f 00001180 020 00 f f 00001200 00b 00
1 00002105 0082 05 0 2 e f 00002104 020 05 f 7 00002184 001 04
2 00003206 0040 06 0 1 c 3 00003204 011 06
3 00004000 0100 07 0 2 f f 00004000 020 00 f f 00004080 020 00
0 00005003 0258 08 1 3 8 f 00005000 040 03 f f 00005100 040 00 f 7 00005200 017 00
1 00006042 00c8 09 1 1 c 3 00006040 033 42
2 00007010 0004 0a 1 1 f 0 00007010 001 10
3 00008001 0200 0b 1 3 e f 00008000 040 01 f f 00008100 040 00 f 1 00008200 001 00
ff
